//--- Bender.yml
package:
  name: addrgen

sources:
  - vec_pkg.sv
  - mem_pkg.sv
  - addrgen_ctrl.sv
  - burst_split.sv
  - addr_queue.sv
  - addrgen.sv
  - target: test
    files:
      - addrgen_sva.sv
      - tb_addrgen.sv

//--- addr_queue.sv
// ****************************************
// FIFO of issued address requests
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module addr_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  mem_pkg::addrgen_req_t data_i,
  output logic                  full_o,
  input  logic                  pop_i,
  output mem_pkg::addrgen_req_t data_o,
  output logic                  valid_o
);

  import mem_pkg::*;

  addrgen_req_t             mem_q [QueueDepth];
  logic [QueuePtrWidth-1:0] wptr_q;
  logic [QueuePtrWidth-1:0] rptr_q;
  logic [QueuePtrWidth:0]   cnt_q;
  logic                     do_push;
  logic                     do_pop;

  assign full_o  = (cnt_q == (QueuePtrWidth+1)'(QueueDepth));
  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[rptr_q];

  // Pops on an empty queue are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == QueuePtrWidth'(QueueDepth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == QueuePtrWidth'(QueueDepth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Occupancy stays put on simultaneous push and pop
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- addrgen.sv
// ****************************************
// Vector memory address generator top
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module addrgen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer
  input  vec_pkg::pe_req_t      pe_req_i,
  input  logic                  pe_req_valid_i,
  input  logic                  core_st_pending_i,
  output logic                  addrgen_ack_o,
  output logic                  addrgen_error_o,
  // AXI read address
  output mem_pkg::ax_req_t      axi_ar_o,
  output logic                  axi_ar_valid_o,
  input  logic                  axi_ar_ready_i,
  // AXI write address
  output mem_pkg::ax_req_t      axi_aw_o,
  output logic                  axi_aw_valid_o,
  input  logic                  axi_aw_ready_i,
  // Load/store units
  output mem_pkg::addrgen_req_t axi_addrgen_req_o,
  output logic                  axi_addrgen_req_valid_o,
  input  logic                  ldu_axi_addrgen_req_ready_i,
  input  logic                  stu_axi_addrgen_req_ready_i
);

  import mem_pkg::*;

  burst_cmd_t   cmd;
  logic         cmd_valid;
  logic         cmd_done;
  logic         queue_full;
  logic         queue_push;
  addrgen_req_t queue_data;
  logic         queue_pop;

  addrgen_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .addrgen_ack_o  (addrgen_ack_o),
    .addrgen_error_o(addrgen_error_o),
    .cmd_o          (cmd),
    .cmd_valid_o    (cmd_valid),
    .cmd_done_i     (cmd_done)
  );

  burst_split i_split (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_i            (cmd),
    .cmd_valid_i      (cmd_valid),
    .cmd_done_o       (cmd_done),
    .core_st_pending_i(core_st_pending_i),
    .queue_full_i     (queue_full),
    .axi_ar_o         (axi_ar_o),
    .axi_ar_valid_o   (axi_ar_valid_o),
    .axi_ar_ready_i   (axi_ar_ready_i),
    .axi_aw_o         (axi_aw_o),
    .axi_aw_valid_o   (axi_aw_valid_o),
    .axi_aw_ready_i   (axi_aw_ready_i),
    .push_o           (queue_push),
    .push_data_o      (queue_data)
  );

  // Either unit taking the head entry pops it
  assign queue_pop = ldu_axi_addrgen_req_ready_i | stu_axi_addrgen_req_ready_i;

  addr_queue i_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (queue_push),
    .data_i (queue_data),
    .full_o (queue_full),
    .pop_i  (queue_pop),
    .data_o (axi_addrgen_req_o),
    .valid_o(axi_addrgen_req_valid_o)
  );

endmodule

`default_nettype wire

//--- addrgen_ctrl.sv
// ****************************************
// Address generator control FSM
// Accepts, checks and acknowledges insns
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module addrgen_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer side
  input  vec_pkg::pe_req_t    pe_req_i,
  input  logic                pe_req_valid_i,
  output logic                addrgen_ack_o,
  output logic                addrgen_error_o,
  // Splitter side
  output mem_pkg::burst_cmd_t cmd_o,
  output logic                cmd_valid_o,
  input  logic                cmd_done_i
);

  import vec_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ISSUE,
    DONE
  } state_e;

  state_e             state_q, state_d;
  logic [NrVInsn-1:0] running_q, running_d;
  burst_cmd_t         cmd_q;
  logic               accept;
  logic               misaligned;

  // New memory insn whose id is not busy here
  assign accept = (state_q == IDLE) && pe_req_valid_i && is_mem_op(pe_req_i.op) &&
                  !running_q[pe_req_i.id];

  // Base address bits below the element width must be zero
  assign misaligned = |(cmd_q.addr & ((addr_t'(1) << cmd_q.vsew) - addr_t'(1)));

  always_comb begin
    state_d         = state_q;
    // Drop ids the sequencer no longer reports as live
    running_d       = running_q & pe_req_i.vinsn_running;
    addrgen_ack_o   = 1'b0;
    addrgen_error_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (accept) begin
          running_d[pe_req_i.id] = 1'b1;
          state_d                = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          // Reject right away, nothing reaches the bus
          addrgen_ack_o   = 1'b1;
          addrgen_error_o = 1'b1;
          state_d         = IDLE;
        end else begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        // Splitter reports the last request transfer
        if (cmd_done_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        addrgen_ack_o = 1'b1;
        state_d       = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      running_q <= '0;
    end else begin
      state_q   <= state_d;
      running_q <= running_d;
    end
  end

  // Latch the insn as a bus-side command on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= '{
        addr    : pe_req_i.base_addr[AddrWidth-1:0],
        // vl elements scaled by the element size
        bytes   : byte_cnt_t'(pe_req_i.vl) << pe_req_i.vsew,
        stride  : pe_req_i.stride[AddrWidth-1:0],
        vsew    : ax_size_t'(pe_req_i.vsew),
        is_load : is_load_op(pe_req_i.op),
        is_burst: is_unit_stride(pe_req_i.op)
      };
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = (state_q == ISSUE);

endmodule

`default_nettype wire

//--- addrgen_sva.sv
// ****************************************
// Bound checks on AXI stability and queue
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module addrgen_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input mem_pkg::ax_req_t axi_ar_i,
  input logic             axi_ar_valid_i,
  input logic             axi_ar_ready_i,
  input mem_pkg::ax_req_t axi_aw_i,
  input logic             axi_aw_valid_i,
  input logic             axi_aw_ready_i,
  input logic             addrgen_ack_i,
  input logic             addrgen_error_i,
  input logic             req_valid_i,
  input logic             queue_full_i,
  input logic             queue_push_i
);

  // Payload frozen until the slave takes it
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_ar_valid_i && !axi_ar_ready_i |=> axi_ar_valid_i && $stable(axi_ar_i))
    else $error("AR request changed before ready");

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_aw_valid_i && !axi_aw_ready_i |=> axi_aw_valid_i && $stable(axi_aw_i))
    else $error("AW request changed before ready");

  // Four entries at most
  no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    queue_full_i |-> !queue_push_i)
    else $error("push into a full request queue");

  reset_low: assert property (@(posedge clk_i)
    !rst_ni |-> !(addrgen_ack_i || addrgen_error_i || axi_ar_valid_i || axi_aw_valid_i ||
                  req_valid_i))
    else $error("control output high during reset");

endmodule

bind addrgen addrgen_sva i_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .axi_ar_i       (axi_ar_o),
  .axi_ar_valid_i (axi_ar_valid_o),
  .axi_ar_ready_i (axi_ar_ready_i),
  .axi_aw_i       (axi_aw_o),
  .axi_aw_valid_i (axi_aw_valid_o),
  .axi_aw_ready_i (axi_aw_ready_i),
  .addrgen_ack_i  (addrgen_ack_o),
  .addrgen_error_i(addrgen_error_o),
  .req_valid_i    (axi_addrgen_req_valid_o),
  .queue_full_i   (queue_full),
  .queue_push_i   (queue_push)
);

`default_nettype wire

//--- burst_split.sv
// ****************************************
// Burst splitter for AR/AW requests
// Page and length limited, or strided
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module burst_split (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Command from control
  input  mem_pkg::burst_cmd_t   cmd_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_done_o,
  // Issue conditions
  input  logic                  core_st_pending_i,
  input  logic                  queue_full_i,
  // AXI address channels
  output mem_pkg::ax_req_t      axi_ar_o,
  output logic                  axi_ar_valid_o,
  input  logic                  axi_ar_ready_i,
  output mem_pkg::ax_req_t      axi_aw_o,
  output logic                  axi_aw_valid_o,
  input  logic                  axi_aw_ready_i,
  // Queue push
  output logic                  push_o,
  output mem_pkg::addrgen_req_t push_data_o
);

  import mem_pkg::*;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_RUN
  } state_e;

  state_e     state_q, state_d;
  // Current address and remaining bytes live in the command itself
  burst_cmd_t cmd_q, cmd_d;
  logic       vld_q, vld_d;

  addr_t      rem;
  addr_t      end_byte;
  addr_t      beats_data;
  addr_t      beats_page;
  addr_t      beats;
  addr_t      covered;
  addr_t      next_addr;
  ax_req_t    ax_req;
  logic       last;
  logic       can_issue;
  logic       ax_valid;
  logic       ax_ready;
  logic       xfer;

  // Request for the current position
  always_comb begin
    rem        = addr_t'(cmd_q.bytes);
    end_byte   = cmd_q.addr + rem - addr_t'(1);
    // Beats from the aligned start up to the beat holding the last byte
    beats_data = (end_byte >> BusSize) - (cmd_q.addr >> BusSize) + addr_t'(1);
    // Beats left before the 4 KiB boundary
    beats_page = addr_t'(PageBytes / DataBytes) - addr_t'(cmd_q.addr[PageBits-1:BusSize]);
    beats      = addr_t'(MaxBeats);
    if (beats_page < beats) begin
      beats = beats_page;
    end
    if (beats_data < beats) begin
      beats = beats_data;
    end

    if (cmd_q.is_burst) begin
      // First burst may start mid-beat, so fewer bytes are covered
      covered   = (beats << BusSize) - (cmd_q.addr & addr_t'(DataBytes - 1));
      next_addr = (cmd_q.addr & ~addr_t'(DataBytes - 1)) + (beats << BusSize);
      ax_req    = '{
        addr : cmd_q.addr,
        len  : beat_len_t'(beats - addr_t'(1)),
        size : ax_size_t'(BusSize),
        burst: BurstIncr
      };
    end else begin
      // One element per request
      covered   = addr_t'(1) << cmd_q.vsew;
      next_addr = cmd_q.addr + cmd_q.stride;
      ax_req    = '{
        addr : cmd_q.addr,
        len  : '0,
        size : cmd_q.vsew,
        burst: BurstFixed
      };
    end

    last = (rem <= covered);
  end

  // Stores hold off while the scalar core has a store in flight
  assign can_issue = (state_q == SPLIT_RUN) && !queue_full_i &&
                     !(!cmd_q.is_load && core_st_pending_i);
  // Once raised, valid stays up until the handshake
  assign ax_valid  = vld_q || can_issue;
  assign ax_ready  = cmd_q.is_load ? axi_ar_ready_i : axi_aw_ready_i;
  assign xfer      = ax_valid && ax_ready;
  assign vld_d     = ax_valid && !ax_ready;

  assign axi_ar_valid_o = ax_valid && cmd_q.is_load;
  assign axi_aw_valid_o = ax_valid && !cmd_q.is_load;
  assign axi_ar_o       = cmd_q.is_load ? ax_req : '0;
  assign axi_aw_o       = cmd_q.is_load ? '0 : ax_req;

  // Every transferred request also goes to the queue
  assign push_o      = xfer;
  assign push_data_o = '{
    addr   : ax_req.addr,
    len    : ax_req.len,
    size   : ax_req.size,
    is_load: cmd_q.is_load
  };
  assign cmd_done_o  = xfer && last;

  always_comb begin
    state_d = state_q;
    cmd_d   = cmd_q;

    unique case (state_q)
      SPLIT_IDLE: begin
        if (cmd_valid_i) begin
          cmd_d   = cmd_i;
          state_d = SPLIT_RUN;
        end
      end
      SPLIT_RUN: begin
        if (xfer) begin
          cmd_d.addr  = next_addr;
          cmd_d.bytes = byte_cnt_t'(rem - covered);
          if (last) begin
            state_d = SPLIT_IDLE;
          end
        end
      end
      default: state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SPLIT_IDLE;
      vld_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      vld_q   <= vld_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cmd_q <= cmd_d;
  end

endmodule

`default_nettype wire

//--- compile.f
vec_pkg.sv
mem_pkg.sv
addrgen_ctrl.sv
burst_split.sv
addr_queue.sv
addrgen.sv
addrgen_sva.sv
tb_addrgen.sv

//--- mem_pkg.sv
// ****************************************
// Memory bus geometry and request types
// ****************************************
`default_nettype none

package mem_pkg;

  // Bus geometry
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataBytes = 8;
  localparam int unsigned PageBytes = 4096;
  localparam int unsigned MaxBeats  = 256;
  // Size code of a full-width beat
  localparam int unsigned BusSize   = $clog2(DataBytes);
  localparam int unsigned PageBits  = $clog2(PageBytes);

  // Request queue towards the load/store units
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);

  // AXI burst codes
  localparam logic [1:0] BurstFixed = 2'b00;
  localparam logic [1:0] BurstIncr  = 2'b01;

  typedef logic [AddrWidth-1:0] addr_t;
  // AXI len, beats minus one
  typedef logic [7:0]           beat_len_t;
  typedef logic [2:0]           ax_size_t;
  // Bytes still to be requested for one command
  typedef logic [23:0]          byte_cnt_t;

  // AR and AW share this payload
  typedef struct packed {
    addr_t      addr;
    beat_len_t  len;
    ax_size_t   size;
    logic [1:0] burst;
  } ax_req_t;

  // Queue entry for the load/store units
  typedef struct packed {
    addr_t     addr;
    beat_len_t len;
    ax_size_t  size;
    logic      is_load;
  } addrgen_req_t;

  // Command from control to the splitter
  typedef struct packed {
    addr_t     addr;
    byte_cnt_t bytes;
    addr_t     stride;
    ax_size_t  vsew;
    logic      is_load;
    logic      is_burst;
  } burst_cmd_t;

endpackage

`default_nettype wire

//--- tb_addrgen.sv
// ****************************************
// Random-stimulus testbench for addrgen
// Checks bursts, strides, stalls and queue
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_addrgen;

  import vec_pkg::*;
  import mem_pkg::*;

  localparam int unsigned NumInsn  = 40;
  localparam int unsigned AckLimit = 20000;

  logic         clk_i;
  logic         rst_ni;
  pe_req_t      pe_req;
  logic         pe_req_valid;
  logic         core_st_pending;
  logic         ack;
  logic         error;
  ax_req_t      ar;
  logic         ar_valid;
  logic         ar_ready;
  ax_req_t      aw;
  logic         aw_valid;
  logic         aw_ready;
  addrgen_req_t lsu_req;
  logic         lsu_req_valid;
  logic         ldu_ready;
  logic         stu_ready;

  // Expected AR/AW requests of the current insn, oldest first
  ax_req_t      exp_ax[$];
  logic         exp_load;
  // Mirror of the request queue
  addrgen_req_t model_q[$];
  int unsigned  errors;
  int unsigned  n_req;
  logic         pend_mode;
  logic         timed_out;
  logic         prev_valid;
  logic         prev_ready;
  ax_req_t      prev_req;

  addrgen uut (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .pe_req_i                   (pe_req),
    .pe_req_valid_i             (pe_req_valid),
    .core_st_pending_i          (core_st_pending),
    .addrgen_ack_o              (ack),
    .addrgen_error_o            (error),
    .axi_ar_o                   (ar),
    .axi_ar_valid_o             (ar_valid),
    .axi_ar_ready_i             (ar_ready),
    .axi_aw_o                   (aw),
    .axi_aw_valid_o             (aw_valid),
    .axi_aw_ready_i             (aw_ready),
    .axi_addrgen_req_o          (lsu_req),
    .axi_addrgen_req_valid_o    (lsu_req_valid),
    .ldu_axi_addrgen_req_ready_i(ldu_ready),
    .stu_axi_addrgen_req_ready_i(stu_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Random bus ready, pop readies and core store activity
  always @(posedge clk_i) begin
    #2;
    ar_ready        = ($urandom % 4) != 0;
    aw_ready        = ($urandom % 4) != 0;
    ldu_ready       = ($urandom % 3) == 0;
    stu_ready       = ($urandom % 5) == 0;
    core_st_pending = pend_mode && (($urandom % 2) == 0);
  end

  // Expected request list from the splitting rules
  function automatic void build_expected(input pe_req_t req);
    addr_t cur;
    addr_t stop;
    addr_t line;
    addr_t n_page;
    addr_t n_data;
    addr_t beats;
    exp_ax.delete();
    exp_load = (req.op == OpVle) || (req.op == OpVlse);
    cur      = req.base_addr[31:0];
    if ((req.op == OpVle) || (req.op == OpVse)) begin
      stop = cur + (addr_t'(req.vl) << req.vsew);
      while (cur < stop) begin
        line   = cur & ~addr_t'(DataBytes - 1);
        // Beats up to the next 4 KiB boundary and up to the data end
        n_page = (((cur | addr_t'(PageBytes - 1)) + 1) - line) / DataBytes;
        n_data = (stop - line + DataBytes - 1) / DataBytes;
        beats  = MaxBeats;
        if (n_page < beats) beats = n_page;
        if (n_data < beats) beats = n_data;
        // Full 8-byte beats, INCR
        exp_ax.push_back('{addr: cur, len: beat_len_t'(beats - 1), size: 3'd3, burst: 2'b01});
        cur = line + beats * DataBytes;
      end
    end else begin
      for (int i = 0; i < int'(req.vl); i++) begin
        exp_ax.push_back('{addr: cur, len: 8'd0, size: ax_size_t'(req.vsew), burst: 2'b00});
        cur = cur + req.stride[31:0];
      end
    end
  endfunction

  task automatic make_req(output pe_req_t req);
    int     s;
    longint sl;
    req      = '0;
    req.id   = vinsn_id_t'($urandom % NrVInsn);
    req.vsew = vsew_t'($urandom % 4);
    req.vl   = vlen_t'(1 + ($urandom % 600));
    case ($urandom % 4)
      0: req.op = OpVle;
      1: req.op = OpVse;
      2: req.op = OpVlse;
      default: req.op = OpVsse;
    endcase
    req.base_addr = elen_t'($urandom & 32'h0FFF_FFFF);
    // Page starts give long bursts that hit the 256-beat limit
    if (($urandom % 4) == 0) req.base_addr[11:0] = '0;
    req.base_addr = req.base_addr & ~((elen_t'(1) << req.vsew) - 1);
    if ((req.vsew != 0) && (($urandom % 6) == 0)) req.base_addr[0] = 1'b1;
    s          = int'($urandom % 129) - 64;
    sl         = s;
    req.stride = elen_t'(sl <<< req.vsew);
  endtask

  // Waits for ack, then drops valid on the next drive slot
  task automatic wait_ack(input logic exp_err);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!ack && (cnt < AckLimit)) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!ack) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout after %0d cycles waiting for addrgen_ack_o", AckLimit);
    end else begin
      if (error !== exp_err) begin
        errors++;
        $display("mismatch addrgen_error_o got %h exp %h", error, exp_err);
      end
      if (exp_ax.size() != 0) begin
        errors++;
        $display("ack came with %0d requests still missing", exp_ax.size());
      end
    end
    @(posedge clk_i);
    #2;
    pe_req_valid = 1'b0;
  endtask

  task automatic run_insn(input pe_req_t req);
    logic exp_err;
    // Base must be a whole multiple of the element size
    exp_err = (req.base_addr % (elen_t'(1) << req.vsew)) != 0;
    exp_ax.delete();
    if (!exp_err) build_expected(req);
    @(posedge clk_i);
    #2;
    pe_req       = req;
    pe_req_valid = 1'b1;
    wait_ack(exp_err);
  endtask

  // Bus and queue monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    logic        ch_valid;
    logic        ch_ready;
    logic        held;
    ax_req_t     ch_req;
    int unsigned qsize;
    if (rst_ni) begin
      ch_valid = ar_valid || aw_valid;
      ch_ready = ar_valid ? ar_ready : aw_ready;
      ch_req   = ar_valid ? ar : aw;
      held     = prev_valid && !prev_ready;
      qsize    = model_q.size();
      if (error && !ack) begin
        errors++;
        $display("addrgen_error_o high without addrgen_ack_o");
      end
      if (ar_valid && aw_valid) begin
        errors++;
        $display("AR and AW valid are high together");
      end
      if (held && (!ch_valid || (ch_req !== prev_req))) begin
        errors++;
        $display("request dropped or changed before its handshake");
      end
      if (aw_valid && core_st_pending && !held) begin
        errors++;
        $display("AW valid raised while a core store was pending");
      end
      // Queue head against the mirror, before this cycle's push
      if (lsu_req_valid !== (qsize != 0)) begin
        errors++;
        $display("mismatch axi_addrgen_req_valid_o got %h exp %h", lsu_req_valid, qsize != 0);
      end else if (lsu_req_valid && (ldu_ready || stu_ready)) begin
        if (lsu_req !== model_q[0]) begin
          errors++;
          $display("mismatch axi_addrgen_req_o got %h exp %h", lsu_req, model_q[0]);
        end
        void'(model_q.pop_front());
      end
      if (ch_valid) begin
        if ((exp_ax.size() == 0) || (exp_load != ar_valid)) begin
          errors++;
          $display("unexpected request on the %s channel", ar_valid ? "AR" : "AW");
        end else if (ch_req !== exp_ax[0]) begin
          errors++;
          $display("mismatch %s got %h exp %h", ar_valid ? "axi_ar_o" : "axi_aw_o", ch_req,
                   exp_ax[0]);
        end
        if (ch_ready) begin
          n_req++;
          if (qsize >= QueueDepth) begin
            errors++;
            $display("request issued into a full queue");
          end
          if (exp_ax.size() != 0) begin
            model_q.push_back('{addr: exp_ax[0].addr, len: exp_ax[0].len,
                                size: exp_ax[0].size, is_load: exp_load});
            void'(exp_ax.pop_front());
          end
        end
      end
      prev_valid = ch_valid;
      prev_ready = ch_ready;
      prev_req   = ch_req;
    end
  end

  initial begin
    pe_req_t req;
    void'($urandom(89));
    rst_ni          = 1'b1;
    pe_req          = '0;
    pe_req_valid    = 1'b0;
    core_st_pending = 1'b0;
    ar_ready        = 1'b0;
    aw_ready        = 1'b0;
    ldu_ready       = 1'b0;
    stu_ready       = 1'b0;
    pend_mode       = 1'b0;
    timed_out       = 1'b0;
    prev_valid      = 1'b0;
    prev_ready      = 1'b0;
    prev_req        = '0;
    errors          = 0;
    n_req           = 0;
    exp_load        = 1'b0;
    // Clean falling edge on reset before the first clock edge
    #1;
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    if (ack || error || ar_valid || aw_valid || lsu_req_valid) begin
      errors++;
      $display("control outputs not low during reset");
    end
    @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Second half runs with random core store activity
    for (int n = 0; n < NumInsn; n++) begin
      if (timed_out) break;
      pend_mode = (n >= NumInsn / 2);
      make_req(req);
      run_insn(req);
    end
    pend_mode = 1'b0;

    // Non-memory opcode is never taken
    if (!timed_out) begin
      make_req(req);
      req.op = OpOther;
      @(posedge clk_i);
      #2;
      pe_req       = req;
      pe_req_valid = 1'b1;
      repeat (10) begin
        @(negedge clk_i);
        if (ack) begin
          errors++;
          $display("non-memory opcode was acknowledged");
        end
      end
      @(posedge clk_i);
      #2;
      pe_req_valid = 1'b0;
    end

    // Id 5 stays live in the mask, so a second id 5 must wait
    if (!timed_out) begin
      make_req(req);
      req.id            = 3'd5;
      req.op            = OpVle;
      req.vsew          = 2'd3;
      req.vl            = 16'd40;
      req.base_addr[2:0] = 3'd0;
      req.vinsn_running = 8'h20;
      run_insn(req);
      exp_ax.delete();
      @(posedge clk_i);
      #2;
      pe_req_valid = 1'b1;
      repeat (20) begin
        @(negedge clk_i);
        if (ack || ar_valid || aw_valid) begin
          errors++;
          $display("insn with a running id was accepted");
        end
      end
      build_expected(req);
      @(posedge clk_i);
      #2;
      pe_req.vinsn_running = '0;
      wait_ack(1'b0);
    end

    $display("errors: %0d, requests transferred: %0d", errors, n_req);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vec_pkg.sv
// ****************************************
// Vector instruction types and opcodes
// ****************************************
`default_nettype none

package vec_pkg;

  // Instruction tracking
  localparam int unsigned NrVInsn = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vinsn_id_t;
  typedef logic [15:0]                vlen_t;
  typedef logic [63:0]                elen_t;
  // Element width code: 0 = 8 bit up to 3 = 64 bit
  typedef logic [1:0]                 vsew_t;
  typedef logic [2:0]                 vop_t;

  // Unit-stride memory opcodes
  localparam vop_t OpVle   = 3'd0;
  localparam vop_t OpVse   = 3'd1;
  // Strided memory opcodes
  localparam vop_t OpVlse  = 3'd2;
  localparam vop_t OpVsse  = 3'd3;
  // Anything the address generator does not handle
  localparam vop_t OpOther = 3'd7;

  // Request from the main sequencer
  typedef struct packed {
    vinsn_id_t          id;
    vop_t               op;
    elen_t              base_addr;
    vlen_t              vl;
    elen_t              stride;
    vsew_t              vsew;
    // Ids the sequencer still reports as live
    logic [NrVInsn-1:0] vinsn_running;
  } pe_req_t;

  // Loads and stores handled by this unit
  function automatic logic is_mem_op(vop_t op);
    return op inside {OpVle, OpVse, OpVlse, OpVsse};
  endfunction

  function automatic logic is_load_op(vop_t op);
    return op inside {OpVle, OpVlse};
  endfunction

  // Unit-stride ops map onto INCR bursts
  function automatic logic is_unit_stride(vop_t op);
    return op inside {OpVle, OpVse};
  endfunction

endpackage

`default_nettype wire
